/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  typedef logic [31:0] word_t;        // Bus data word
  typedef logic [30:2] mmio_addr_t;   // Word address, byte offset dropped
  typedef logic [3:0]  byte_en_t;     // One enable per data byte
  typedef logic [18:0] region_t;      // 4 KB region number, addr[30:12]

  localparam region_t REGION_LEDSW = 19'd0;
  localparam region_t REGION_UART  = 19'd1;

  typedef logic [9:0] led_r_t;        // Red LEDs
  typedef logic [7:0] led_g_t;        // Green LEDs
  typedef logic [9:0] sw_t;           // Slide switches
  typedef logic [3:0] btn_t;          // Push buttons

  typedef logic [7:0] uart_byte_t;    // One 8N1 character

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx import soc_pkg::*; #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       clkrst_core_clk,
  input  logic       reset,
  input  logic       start,
  input  uart_byte_t tx_data,
  output logic       busy,
  output logic       tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  tx_state_t        state;
  logic [CNT_W-1:0] clk_cnt;   // Cycles within the current bit
  logic [2:0]       bit_idx;
  uart_byte_t       shreg;
  logic             bit_end;

  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else begin
      clk_cnt <= (state == TX_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
      case (state)
        TX_IDLE:  if (start) state <= TX_START;
        TX_START: if (bit_end) begin
          state   <= TX_DATA;
          bit_idx <= '0;
        end
        TX_DATA:  if (bit_end) begin
          if (bit_idx == 3'd7) state <= TX_STOP;   // Last data bit done
          bit_idx <= bit_idx + 1'b1;
        end
        TX_STOP:  if (bit_end) state <= TX_IDLE;
        default:  state <= TX_IDLE;
      endcase
    end
  end

  // LSB goes out first
  always_ff @(posedge clkrst_core_clk) begin
    if (state == TX_IDLE && start)
      shreg <= tx_data;
    else if (state == TX_DATA && bit_end)
      shreg <= shreg >> 1;
  end

  assign busy = (state != TX_IDLE);
  assign tx   = (state == TX_START) ? 1'b0 :
                (state == TX_DATA)  ? shreg[0] : 1'b1;   // Idle and stop are high

endmodule

`default_nettype wire

/* hw/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx import soc_pkg::*; #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       clkrst_core_clk,
  input  logic       reset,
  input  logic       rx,
  output uart_byte_t rx_data,
  output logic       rx_done
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  rx_state_t        state;
  logic             rx_meta, rx_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  uart_byte_t       shreg;
  logic             bit_end, half_hit;

  assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign half_hit = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));   // Middle of start bit

  // Line idles high, so reset the synchronizer to 1
  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      clk_cnt <= clk_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync) state <= RX_START;   // Falling edge seen
        end
        RX_START: if (half_hit) begin
          clk_cnt <= '0;                     // Realign to mid-bit
          bit_idx <= '0;
          state   <= rx_sync ? RX_IDLE : RX_DATA;   // Glitch, not a start bit
        end
        RX_DATA: if (bit_end) begin
          clk_cnt <= '0;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= RX_STOP;
        end
        RX_STOP: if (bit_end) begin
          clk_cnt <= '0;
          rx_done <= rx_sync;   // Framing error drops the byte
          state   <= RX_IDLE;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clkrst_core_clk) begin
    if (state == RX_DATA && bit_end)
      shreg <= {rx_sync, shreg[7:1]};
  end

  assign rx_data = shreg;   // Stable while rx_done is high

endmodule

`default_nettype wire

/* hw/soc_uart.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_uart import soc_pkg::*; #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic  clkrst_core_clk,
  input  logic  reset,
  input  logic  reg_sel,      // 0 = data, 1 = status
  input  logic  write,
  input  word_t data_in,
  output word_t rdata,
  input  logic  ext_uart_rx,
  output logic  ext_uart_tx
);

  logic       tx_start, tx_busy;
  uart_byte_t rx_data;
  logic       rx_done;
  uart_byte_t rx_hold;       // Last received character
  logic       rx_valid, rx_overrun;
  logic       flag_clr;

  // Launch only when idle, busy writes are lost
  assign tx_start = write && !reg_sel && !tx_busy;
  assign flag_clr = write && reg_sel && data_in[1];   // W1C on bit 1

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx0 (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .start           (tx_start),
    .tx_data         (data_in[7:0]),
    .busy            (tx_busy),
    .tx              (ext_uart_tx)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx0 (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .rx              (ext_uart_rx),
    .rx_data         (rx_data),
    .rx_done         (rx_done)
  );

  always_ff @(posedge clkrst_core_clk) begin
    if (rx_done)
      rx_hold <= rx_data;   // New byte always replaces the old one
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end else if (rx_done) begin
      rx_valid   <= 1'b1;
      rx_overrun <= rx_valid && !flag_clr;   // Unread byte got overwritten
    end else if (flag_clr) begin
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end
  end

  assign rdata = reg_sel ? {29'b0, rx_overrun, rx_valid, tx_busy}
                         : {24'b0, rx_hold};

endmodule

`default_nettype wire

/* hw/soc_ledsw.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_ledsw import soc_pkg::*; (
  input  logic     clkrst_core_clk,
  input  logic     reset,
  input  logic     reg_sel,        // addr[2], 0 = LED reg, 1 = inputs
  input  word_t    data_in,
  input  byte_en_t wren,
  output word_t    rdata,
  output led_r_t   ext_led_r,
  output led_g_t   ext_led_g,
  input  sw_t      ext_switches,
  input  btn_t     ext_buttons
);

  logic [17:0] led_q;   // {green, red}
  word_t       led_next;
  sw_t         sw_meta, sw_sync;
  btn_t        btn_meta, btn_sync;

  // Merge the enabled bytes into the current LED word
  always_comb begin
    led_next = {14'b0, led_q};
    for (int i = 0; i < 4; i++) begin
      if (wren[i])
        led_next[8*i +: 8] = data_in[8*i +: 8];
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      led_q <= '0;
    end else if (!reg_sel && (wren != '0)) begin
      led_q <= led_next[17:0];   // Upper bits have no storage
    end
  end

  // Two-flop synchronizer for the async pins
  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      sw_meta  <= '0;
      sw_sync  <= '0;
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      sw_meta  <= ext_switches;
      sw_sync  <= sw_meta;
      btn_meta <= ext_buttons;
      btn_sync <= btn_meta;
    end
  end

  assign ext_led_r = led_q[9:0];
  assign ext_led_g = led_q[17:10];

  assign rdata = reg_sel ? {18'b0, btn_sync, sw_sync}   // Buttons above switches
                         : {14'b0, led_q};

endmodule

`default_nettype wire

/* hw/soc_mmio.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_mmio import soc_pkg::*; (
  input  mmio_addr_t addr,
  input  byte_en_t   wren,
  output word_t      data_out,
  output byte_en_t   ledsw_wren,   // Masked enables for region 0
  output logic       uart_write,   // Single strobe for region 1
  input  word_t      ledsw_rdata,
  input  word_t      uart_rdata
);

  region_t region;

  assign region = addr[30:12];   // 4 KB granularity

  // Steer writes and pick the read word by region
  always_comb begin
    ledsw_wren = '0;
    uart_write = 1'b0;
    data_out   = '0;   // Unmapped regions read as zero
    case (region)
      REGION_LEDSW: begin
        ledsw_wren = wren;
        data_out   = ledsw_rdata;
      end
      REGION_UART: begin
        uart_write = |wren;   // Any byte lane counts as a write
        data_out   = uart_rdata;
      end
      default: ;   // I2C, SD and other unmapped regions swallow writes
    endcase
  end

endmodule

`default_nettype wire

/* hw/soc_periph_top.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_periph_top import soc_pkg::*; #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       clkrst_core_clk,
  input  logic       reset,
  input  mmio_addr_t addr,
  input  word_t      data_in,
  input  byte_en_t   wren,
  output word_t      data_out,
  output led_r_t     ext_led_r,
  output led_g_t     ext_led_g,
  input  sw_t        ext_switches,
  input  btn_t       ext_buttons,
  input  logic       ext_uart_rx,
  output logic       ext_uart_tx
);

  byte_en_t ledsw_wren;
  logic     uart_write;
  word_t    ledsw_rdata, uart_rdata;

  soc_mmio mmio0 (
    .addr        (addr),
    .wren        (wren),
    .data_out    (data_out),
    .ledsw_wren  (ledsw_wren),
    .uart_write  (uart_write),
    .ledsw_rdata (ledsw_rdata),
    .uart_rdata  (uart_rdata)
  );

  soc_ledsw ledsw0 (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .reg_sel         (addr[2]),   // Register select inside the region
    .data_in         (data_in),
    .wren            (ledsw_wren),
    .rdata           (ledsw_rdata),
    .ext_led_r       (ext_led_r),
    .ext_led_g       (ext_led_g),
    .ext_switches    (ext_switches),
    .ext_buttons     (ext_buttons)
  );

  soc_uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart0 (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .reg_sel         (addr[2]),
    .write           (uart_write),
    .data_in         (data_in),
    .rdata           (uart_rdata),
    .ext_uart_rx     (ext_uart_rx),
    .ext_uart_tx     (ext_uart_tx)
  );

endmodule

`default_nettype wire

/* bench/soc_periph_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_periph_chk (
  input logic clk,
  input logic reset,
  input logic tx_busy,
  input logic tx_start,
  input logic tx,
  input logic rx_valid,
  input logic rx_overrun
);

  int fails = 0;   // Assertion failures so far

  // Idle line sits at the stop level
  idle_high: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> tx)
    else begin
      fails++;
      $error("UART tx line is low while the transmitter is idle");
    end

  // Launch only from idle, start bit follows at once
  no_start_busy: assert property (@(posedge clk) disable iff (reset)
                                  tx_start |=> $rose(tx_busy) && !tx)
    else begin
      fails++;
      $error("UART transmit start pulsed while busy or did not begin a frame");
    end

  // Overrun needs a byte that was still unread
  overrun_valid: assert property (@(posedge clk) disable iff (reset)
                                  $rose(rx_overrun) |-> $past(rx_valid) && rx_valid)
    else begin
      fails++;
      $error("UART overrun flag set without an unread byte");
    end

endmodule

bind soc_uart soc_periph_chk chk0 (
  .clk        (clkrst_core_clk),
  .reset      (reset),
  .tx_busy    (tx_busy),
  .tx_start   (tx_start),
  .tx         (ext_uart_tx),
  .rx_valid   (rx_valid),
  .rx_overrun (rx_overrun)
);

`default_nettype wire

/* bench/soc_periph_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_periph_tb import soc_pkg::*; ();

  localparam int CLKS_PER_BIT = 16;
  localparam int MAX_CYCLES   = 6000;   // 10 frames of ~170 cycles plus short tests, 2x margin

  logic       clk, reset;
  mmio_addr_t addr;
  word_t      data_in, data_out;
  byte_en_t   wren;
  led_r_t     ext_led_r;
  led_g_t     ext_led_g;
  sw_t        ext_switches;
  btn_t       ext_buttons;
  logic       uart_line;   // tx looped back into rx

  int          seed = 32'h8c12;
  int          cycles = 0;
  int          errors, test_errors, tests_ok, tests_bad, r;
  logic [17:0] led_model;   // Expected {green, red}
  word_t       rd, rnd, rnd2;
  uart_byte_t  sent;

  soc_periph_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut0 (
    .clkrst_core_clk (clk),
    .reset           (reset),
    .addr            (addr),
    .data_in         (data_in),
    .wren            (wren),
    .data_out        (data_out),
    .ext_led_r       (ext_led_r),
    .ext_led_g       (ext_led_g),
    .ext_switches    (ext_switches),
    .ext_buttons     (ext_buttons),
    .ext_uart_rx     (uart_line),
    .ext_uart_tx     (uart_line)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // Byte address {region, offset} down to the word address
  function automatic mmio_addr_t reg_addr(input int region, input logic offset4);
    logic [30:0] byte_addr;
    byte_addr = {region[18:0], 9'd0, offset4, 2'b00};
    return byte_addr[30:2];
  endfunction

  // Each enabled byte lane replaces its 8 bits, only 18 bits exist
  function automatic logic [17:0] model_led_write(input logic [17:0] cur, input word_t d,
                                                  input byte_en_t en);
    word_t mask;
    mask = {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
    return (cur & ~mask[17:0]) | (d[17:0] & mask[17:0]);
  endfunction

  task automatic bus_write(input mmio_addr_t a, input word_t d, input byte_en_t en);
    addr    = a;
    data_in = d;
    wren    = en;
    @(posedge clk);
    #10;
    wren = '0;   // Strobe lasts one cycle
  endtask

  task automatic bus_read(input mmio_addr_t a, output word_t d);
    addr = a;
    wren = '0;
    #80;   // Just before the next edge
    d = data_out;
    @(posedge clk);
    #10;
  endtask

  // Bounded by the cycle counter
  task automatic poll_status(input int bit_idx, input logic level);
    word_t s;
    do bus_read(reg_addr(1, 1'b1), s); while (s[bit_idx] !== level);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_led_r(input led_r_t exp, input led_r_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t ext_led_r: expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_led_g(input led_g_t exp, input led_g_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t ext_led_g: expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s: expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic end_test(input string name);
    if (errors == test_errors) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  // LED pins against the model, mid-cycle where both are settled
  always @(negedge clk) begin
    if (!reset) begin
      check_led_r(led_model[9:0], ext_led_r);
      check_led_g(led_model[17:10], ext_led_g);
    end
  end

  initial begin
    reset        = 1'b1;
    addr         = '0;
    data_in      = '0;
    wren         = '0;
    ext_switches = '0;
    ext_buttons  = '0;
    led_model    = '0;
    errors       = 0;
    test_errors  = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;

    bus_read(reg_addr(0, 1'b0), rd);
    check_word("led reg", 32'h0, rd);
    bus_read(reg_addr(1, 1'b1), rd);
    check_word("uart status", 32'h0, rd);
    check_led_r('0, ext_led_r);
    check_led_g('0, ext_led_g);
    check_bit("ext_uart_tx", 1'b1, uart_line);   // Idle line high
    end_test("reset state");

    repeat (20) begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      bus_write(reg_addr(0, 1'b0), rnd, rnd2[3:0]);
      led_model = model_led_write(led_model, rnd, rnd2[3:0]);
      check_led_r(led_model[9:0], ext_led_r);
      check_led_g(led_model[17:10], ext_led_g);
      bus_read(reg_addr(0, 1'b0), rd);
      check_word("led reg", {14'b0, led_model}, rd);
    end
    end_test("led byte writes");

    repeat (4) begin
      rnd          = $random(seed);
      ext_switches = rnd[9:0];
      ext_buttons  = rnd[13:10];
      repeat (3) @(posedge clk);   // Covers the 2-cycle sync lag
      #10;
      bus_read(reg_addr(0, 1'b1), rd);
      check_word("switch word", (word_t'(ext_buttons) << 10) | word_t'(ext_switches), rd);
    end
    end_test("switch readback");

    repeat (8) begin
      rnd  = $random(seed);
      sent = rnd[7:0];
      bus_write(reg_addr(1, 1'b0), {24'b0, sent}, 4'h1);
      bus_read(reg_addr(1, 1'b1), rd);
      check_word("tx_busy", 32'h1, rd & 32'h1);
      bus_write(reg_addr(1, 1'b0), {24'b0, ~sent}, 4'h1);   // Busy, so dropped
      poll_status(1, 1'b1);
      bus_read(reg_addr(1, 1'b0), rd);
      check_word("uart data", {24'b0, sent}, rd);
      bus_write(reg_addr(1, 1'b1), 32'h2, 4'hf);   // Clear rx flags
      poll_status(0, 1'b0);
      bus_read(reg_addr(1, 1'b1), rd);
      check_word("uart status", 32'h0, rd);   // No second frame
    end
    end_test("uart loopback");

    rnd = $random(seed);
    bus_write(reg_addr(1, 1'b0), {24'b0, rnd[7:0]}, 4'h1);
    poll_status(0, 1'b0);
    bus_write(reg_addr(1, 1'b0), {24'b0, rnd[15:8]}, 4'h1);
    poll_status(0, 1'b0);
    bus_read(reg_addr(1, 1'b1), rd);
    check_word("uart status", 32'h6, rd);   // Valid and overrun
    bus_read(reg_addr(1, 1'b0), rd);
    check_word("uart data", {24'b0, rnd[15:8]}, rd);
    bus_write(reg_addr(1, 1'b1), 32'h2, 4'hf);
    bus_read(reg_addr(1, 1'b1), rd);
    check_word("uart status", 32'h0, rd);
    end_test("uart overrun");

    for (r = 2; r < 4; r++) begin
      bus_read(reg_addr(r, 1'b0), rd);
      check_word("unmapped read", 32'h0, rd);
      bus_read(reg_addr(r, 1'b1), rd);
      check_word("unmapped read", 32'h0, rd);
      rnd = $random(seed);
      bus_write(reg_addr(r, 1'b0), rnd, 4'hf);   // Must not reach the LEDs
    end
    check_led_r(led_model[9:0], ext_led_r);
    check_led_g(led_model[17:10], ext_led_g);
    bus_read(reg_addr(0, 1'b0), rd);
    check_word("led reg", {14'b0, led_model}, rd);
    end_test("unmapped regions");

    if (dut0.uart0.chk0.fails != 0) begin
      $display("UART assertions failed %0d times", dut0.uart0.chk0.fails);
      errors += dut0.uart0.chk0.fails;
    end
    $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/soc_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/soc_uart.sv
hw/soc_ledsw.sv
hw/soc_mmio.sv
hw/soc_periph_top.sv
bench/soc_periph_chk.sv
bench/soc_periph_tb.sv

/* Makefile */
TOP = soc_periph_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
